/* source/modbus_pkg.sv */
/*
 * Shared Modbus RTU slave definitions
 * Data widths, function codes, executor states and the CRC-16 byte step
 */
`default_nettype none

package modbus_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [15:0] crc_t;
  typedef logic [7:0]  buf_idx_t;
  typedef logic [8:0]  buf_len_t;
  typedef logic [31:0] coil_t;

  // Supported function codes
  typedef enum logic [7:0] {
    fc_read_coils   = 8'h01,
    fc_read_inputs  = 8'h02,
    fc_read_holding = 8'h03,
    fc_write_coil   = 8'h05,
    fc_write_reg    = 8'h06,
    fc_write_regs   = 8'h10
  } func_t;

  typedef enum logic [3:0] {
    st_idle, st_hdr, st_check, st_resp_hdr, st_bits, st_reg_addr, st_reg_hi,
    st_reg_lo, st_wr_hi, st_wr_lo, st_echo, st_send
  } exec_state_t;

  localparam crc_t  CRC_INIT = 16'hFFFF;
  localparam crc_t  CRC_POLY = 16'hA001;
  localparam word_t COIL_ON  = 16'hFF00;

  // Fold one byte into the CRC starting with the LSB
  function automatic crc_t crc16_step(crc_t crc_in, byte_t data);
    crc_t c;
    c = crc_in ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

endpackage

`default_nettype wire

/* source/modbus_if.sv */
/*
 * Request frame interface between receive buffer and executor
 * Response frame interface between executor and transmit buffer
 */
`default_nettype none

interface rx_frame_if import modbus_pkg::*; ();
  logic     frame_ready;
  buf_len_t frame_len;
  logic     crc_ok;
  byte_t    rd_data;
  buf_idx_t rd_idx;
  logic     release_frame;

  modport rx (
    output frame_ready, frame_len, crc_ok, rd_data,
    input  rd_idx, release_frame
  );

  modport exec (
    input  frame_ready, frame_len, crc_ok, rd_data,
    output rd_idx, release_frame
  );
endinterface

interface tx_frame_if import modbus_pkg::*; ();
  logic     wr_en;
  buf_idx_t wr_idx;
  byte_t    wr_data;
  logic     send;
  buf_len_t resp_len;
  logic     busy;

  modport exec (
    output wr_en, wr_idx, wr_data, send, resp_len,
    input  busy
  );

  modport tx (
    input  wr_en, wr_idx, wr_data, send, resp_len,
    output busy
  );
endinterface

`default_nettype wire

/* source/rtu_rx_frame.sv */
/*
 * Request frame collector with byte buffer, length count and running CRC
 */
`default_nettype none

module rtu_rx_frame import modbus_pkg::*; #(
  parameter int BUF_DEPTH = 256
) (
  input  logic   clk,
  input  logic   rst,
  input  byte_t  rx_byte,
  input  logic   rx_valid,
  input  logic   frame_start,
  input  logic   frame_end,
  rx_frame_if.rx frame
);

  byte_t    buf_mem [BUF_DEPTH];
  buf_len_t len;
  crc_t     crc;
  logic     collecting;
  logic     ready;
  logic     start;
  logic     store;
  buf_idx_t wr_ptr;
  buf_idx_t store_ptr;

  // A new frame is only accepted while the previous one is released
  assign start = frame_start && !collecting && !ready;
  assign store = rx_valid && (collecting || start);

  // Oversized frames keep writing the last slot
  assign wr_ptr    = (len >= buf_len_t'(BUF_DEPTH)) ? buf_idx_t'(BUF_DEPTH - 1) : len[7:0];
  assign store_ptr = start ? '0 : wr_ptr;

  always_ff @(posedge clk) begin
    if (store) begin
      buf_mem[store_ptr] <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      collecting <= 1'b0;
      ready      <= 1'b0;
      len        <= '0;
      crc        <= CRC_INIT;
    end else begin
      if (start) begin
        collecting <= 1'b1;
        len        <= store ? buf_len_t'(1) : '0;
        crc        <= store ? crc16_step(CRC_INIT, rx_byte) : CRC_INIT;
      end else if (collecting) begin
        if (rx_valid) begin
          crc <= crc16_step(crc, rx_byte);
          if (len != buf_len_t'(BUF_DEPTH)) begin
            len <= len + 9'd1;
          end
        end
        if (frame_end) begin
          collecting <= 1'b0;
          ready      <= 1'b1;
        end
      end
      if (frame.release_frame) begin
        ready <= 1'b0;
      end
    end
  end

  // Residue over data plus received CRC is zero for a good frame
  assign frame.crc_ok      = (len >= 9'd4) && (crc == 16'h0000);
  assign frame.frame_ready = ready;
  assign frame.frame_len   = len;
  assign frame.rd_data     = buf_mem[frame.rd_idx];

endmodule

`default_nettype wire

/* source/holding_reg_file.sv */
/*
 * Holding register memory with synchronous read and write ports
 */
`default_nettype none

module holding_reg_file import modbus_pkg::*; #(
  parameter int REG_WORDS = 64
) (
  input  logic  clk,
  input  word_t rd_addr,
  output word_t rd_data,
  input  logic  wr_en,
  input  word_t wr_addr,
  input  word_t wr_data
);

  localparam int AW = $clog2(REG_WORDS);

  word_t mem [REG_WORDS];

  // Register index wraps on the low address bits
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr[AW-1:0]] <= wr_data;
    end
    rd_data <= mem[rd_addr[AW-1:0]];
  end

endmodule

`default_nettype wire

/* source/rtu_slave_exec.sv */
/*
 * Request executor with header decode, CRC and length checks,
 * coil image, register access and byte-serial response building
 */
`default_nettype none

module rtu_slave_exec import modbus_pkg::*; #(
  parameter word_t REG_BASE = 16'h0000
) (
  input  logic       clk,
  input  logic       rst,
  rx_frame_if.exec   frame,
  tx_frame_if.exec   tx,
  output word_t      reg_rd_addr,
  input  word_t      reg_rd_data,
  output logic       reg_wr_en,
  output word_t      reg_wr_addr,
  output word_t      reg_wr_data,
  input  coil_t      di_status,
  output coil_t      do_wdata,
  output coil_t      do_wmask,
  output logic       do_we,
  output logic       crc_err
);

  exec_state_t state;
  buf_idx_t    ridx;
  buf_len_t    widx;
  byte_t       dev_addr, func, byte_cnt, hi_byte;
  word_t       start_addr, qty;
  coil_t       coil_img;
  logic        release_q, send_q, wr_en_q;
  buf_idx_t    wr_idx_q;
  byte_t       wr_data_q;

  coil_t       bit_win;
  byte_t       bit_mask;
  word_t       reg_idx;
  buf_len_t    need_len;
  logic        func_ok;

  // Bit window at the current position with the tail byte masked to the quantity
  assign bit_win  = ((func == fc_read_coils) ? coil_img : di_status) >> start_addr;
  assign bit_mask = (qty >= 16'd8) ? 8'hFF : ~(8'hFF << qty[2:0]);
  assign reg_idx  = start_addr - REG_BASE;

  // Write-multiple frames must hold all announced data bytes
  assign need_len = (func == fc_write_regs) ? 9'd9 + {1'b0, byte_cnt} : 9'd8;
  assign func_ok  = func inside {fc_read_coils, fc_read_inputs, fc_read_holding,
                                 fc_write_coil, fc_write_reg, fc_write_regs};

  assign frame.rd_idx        = ridx;
  assign frame.release_frame = release_q;
  assign tx.wr_en            = wr_en_q;
  assign tx.wr_idx           = wr_idx_q;
  assign tx.wr_data          = wr_data_q;
  assign tx.send             = send_q;
  assign tx.resp_len         = widx;
  assign reg_rd_addr         = reg_idx;
  assign do_wdata            = coil_img;

  // ====================================================================
  // Executor FSM
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      ridx      <= '0;
      widx      <= '0;
      release_q <= 1'b0;
      send_q    <= 1'b0;
      wr_en_q   <= 1'b0;
      reg_wr_en <= 1'b0;
      coil_img  <= '0;
      do_wmask  <= '0;
      do_we     <= 1'b0;
      crc_err   <= 1'b0;
    end else begin
      release_q <= 1'b0;
      send_q    <= 1'b0;
      wr_en_q   <= 1'b0;
      reg_wr_en <= 1'b0;
      do_we     <= 1'b0;
      case (state)
        st_idle: begin
          if (frame.frame_ready && !release_q) begin
            ridx  <= '0;
            state <= st_hdr;
          end
        end
        st_hdr: begin
          case (ridx)
            8'd0:    dev_addr         <= frame.rd_data;
            8'd1:    func             <= frame.rd_data;
            8'd2:    start_addr[15:8] <= frame.rd_data;
            8'd3:    start_addr[7:0]  <= frame.rd_data;
            8'd4:    qty[15:8]        <= frame.rd_data;
            8'd5:    qty[7:0]         <= frame.rd_data;
            default: byte_cnt         <= frame.rd_data;
          endcase
          ridx <= ridx + 8'd1;
          if (ridx == 8'd6) begin
            state <= st_check;
          end
        end
        st_check: begin
          if (!frame.crc_ok) begin
            crc_err   <= 1'b1;
            release_q <= 1'b1;
            state     <= st_idle;
          end else if (!func_ok || frame.frame_len < need_len) begin
            release_q <= 1'b1;
            state     <= st_idle;
          end else if (!tx.busy) begin
            widx <= '0;
            ridx <= '0;
            case (func)
              fc_read_coils, fc_read_inputs, fc_read_holding: state <= st_resp_hdr;
              fc_write_coil: begin
                coil_img[start_addr[4:0]] <= (qty == COIL_ON);
                do_wmask <= coil_t'(1) << start_addr[4:0];
                do_we    <= 1'b1;
                state    <= st_echo;
              end
              fc_write_reg: begin
                reg_wr_en   <= 1'b1;
                reg_wr_addr <= reg_idx;
                reg_wr_data <= qty;
                state       <= st_echo;
              end
              default: begin
                // Register data of a write-multiple request follows the byte count
                ridx  <= 8'd7;
                state <= st_wr_hi;
              end
            endcase
          end
        end
        st_resp_hdr: begin
          wr_en_q  <= 1'b1;
          wr_idx_q <= widx[7:0];
          widx     <= widx + 9'd1;
          case (widx)
            9'd0: wr_data_q <= dev_addr;
            9'd1: wr_data_q <= func;
            default: begin
              wr_data_q <= (func == fc_read_holding) ? byte_t'(qty << 1)
                                                     : byte_t'((qty + 16'd7) >> 3);
              if (qty == 16'd0) state <= st_send;
              else if (func == fc_read_holding) state <= st_reg_addr;
              else state <= st_bits;
            end
          endcase
        end
        st_bits: begin
          wr_en_q    <= 1'b1;
          wr_idx_q   <= widx[7:0];
          wr_data_q  <= bit_win[7:0] & bit_mask;
          widx       <= widx + 9'd1;
          start_addr <= start_addr + 16'd8;
          qty        <= qty - 16'd8;
          if (qty <= 16'd8) begin
            state <= st_send;
          end
        end
        // One cycle for the register read latency
        st_reg_addr: state <= st_reg_hi;
        st_reg_hi: begin
          wr_en_q   <= 1'b1;
          wr_idx_q  <= widx[7:0];
          wr_data_q <= reg_rd_data[15:8];
          widx      <= widx + 9'd1;
          state     <= st_reg_lo;
        end
        st_reg_lo: begin
          wr_en_q    <= 1'b1;
          wr_idx_q   <= widx[7:0];
          wr_data_q  <= reg_rd_data[7:0];
          widx       <= widx + 9'd1;
          start_addr <= start_addr + 16'd1;
          qty        <= qty - 16'd1;
          state      <= (qty == 16'd1) ? st_send : st_reg_addr;
        end
        st_wr_hi: begin
          if (byte_cnt < 8'd2) begin
            ridx  <= '0;
            state <= st_echo;
          end else begin
            hi_byte <= frame.rd_data;
            ridx    <= ridx + 8'd1;
            state   <= st_wr_lo;
          end
        end
        st_wr_lo: begin
          reg_wr_en   <= 1'b1;
          reg_wr_addr <= reg_idx;
          reg_wr_data <= {hi_byte, frame.rd_data};
          start_addr  <= start_addr + 16'd1;
          byte_cnt    <= byte_cnt - 8'd2;
          ridx        <= ridx + 8'd1;
          state       <= st_wr_hi;
        end
        st_echo: begin
          // Address, function, start and quantity or value
          wr_en_q   <= 1'b1;
          wr_idx_q  <= widx[7:0];
          wr_data_q <= frame.rd_data;
          widx      <= widx + 9'd1;
          ridx      <= ridx + 8'd1;
          if (ridx == 8'd5) begin
            state <= st_send;
          end
        end
        st_send: begin
          send_q    <= 1'b1;
          release_q <= 1'b1;
          state     <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/rtu_tx_frame.sv */
/*
 * Response transmitter with frame buffer and ready-paced byte streaming
 * CRC computed on the fly and appended low byte first
 */
`default_nettype none

module rtu_tx_frame import modbus_pkg::*; #(
  parameter int BUF_DEPTH = 256
) (
  input  logic   clk,
  input  logic   rst,
  tx_frame_if.tx tx,
  input  logic   tx_ready,
  output byte_t  tx_byte,
  output logic   tx_valid
);

  byte_t    buf_mem [BUF_DEPTH];
  buf_len_t len;
  buf_len_t idx;
  crc_t     crc;
  logic     busy;
  byte_t    next_byte;

  always_ff @(posedge clk) begin
    if (tx.wr_en) begin
      buf_mem[tx.wr_idx] <= tx.wr_data;
    end
  end

  // Payload bytes followed by the CRC low and high bytes
  always_comb begin
    if (idx < len) begin
      next_byte = buf_mem[idx[7:0]];
    end else if (idx == len) begin
      next_byte = crc[7:0];
    end else begin
      next_byte = crc[15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      tx_valid <= 1'b0;
      len      <= '0;
      idx      <= '0;
      crc      <= CRC_INIT;
    end else begin
      tx_valid <= 1'b0;
      if (tx.send && !busy) begin
        busy <= 1'b1;
        len  <= tx.resp_len;
        idx  <= '0;
        crc  <= CRC_INIT;
      end else if (busy && tx_ready) begin
        tx_valid <= 1'b1;
        tx_byte  <= next_byte;
        idx      <= idx + 9'd1;
        if (idx < len) begin
          crc <= crc16_step(crc, next_byte);
        end
        if (idx == len + 9'd1) begin
          busy <= 1'b0;
        end
      end
    end
  end

  assign tx.busy = busy;

endmodule

`default_nettype wire

/* source/modbus_rtu_slave.sv */
/*
 * Modbus RTU slave top level
 * Receive buffer, executor, holding registers and transmit buffer
 */
`default_nettype none

module modbus_rtu_slave import modbus_pkg::*; #(
  parameter int    REG_WORDS = 64,
  parameter word_t REG_BASE  = 16'h0000,
  parameter int    BUF_DEPTH = 256
) (
  input  logic  clk,
  input  logic  rst,
  // UART bridge byte stream
  input  byte_t rx_byte,
  input  logic  rx_valid,
  input  logic  frame_start,
  input  logic  frame_end,
  output byte_t tx_byte,
  output logic  tx_valid,
  input  logic  tx_ready,
  // Digital I/O
  input  coil_t di_status,
  output coil_t do_wdata,
  output coil_t do_wmask,
  output logic  do_we,
  // Status
  output logic  crc_err
);

  rx_frame_if rx_frame_bus ();
  tx_frame_if tx_frame_bus ();

  word_t reg_rd_addr;
  word_t reg_rd_data;
  logic  reg_wr_en;
  word_t reg_wr_addr;
  word_t reg_wr_data;

  rtu_rx_frame #(.BUF_DEPTH(BUF_DEPTH)) rtu_rx_frame_inst (
    .clk        (clk),
    .rst        (rst),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .frame_start(frame_start),
    .frame_end  (frame_end),
    .frame      (rx_frame_bus.rx)
  );

  rtu_slave_exec #(.REG_BASE(REG_BASE)) rtu_slave_exec_inst (
    .clk        (clk),
    .rst        (rst),
    .frame      (rx_frame_bus.exec),
    .tx         (tx_frame_bus.exec),
    .reg_rd_addr(reg_rd_addr),
    .reg_rd_data(reg_rd_data),
    .reg_wr_en  (reg_wr_en),
    .reg_wr_addr(reg_wr_addr),
    .reg_wr_data(reg_wr_data),
    .di_status  (di_status),
    .do_wdata   (do_wdata),
    .do_wmask   (do_wmask),
    .do_we      (do_we),
    .crc_err    (crc_err)
  );

  holding_reg_file #(.REG_WORDS(REG_WORDS)) holding_reg_file_inst (
    .clk    (clk),
    .rd_addr(reg_rd_addr),
    .rd_data(reg_rd_data),
    .wr_en  (reg_wr_en),
    .wr_addr(reg_wr_addr),
    .wr_data(reg_wr_data)
  );

  rtu_tx_frame #(.BUF_DEPTH(BUF_DEPTH)) rtu_tx_frame_inst (
    .clk     (clk),
    .rst     (rst),
    .tx      (tx_frame_bus.tx),
    .tx_ready(tx_ready),
    .tx_byte (tx_byte),
    .tx_valid(tx_valid)
  );

endmodule

`default_nettype wire

/* tb/modbus_rtu_slave_checker.sv */
/*
 * Protocol assertions bound to the slave top level
 */
`default_nettype none

module modbus_rtu_slave_checker (
  input logic clk,
  input logic rst,
  input logic tx_valid,
  input logic tx_ready,
  input logic do_we
);
  timeunit 1ns;
  timeprecision 100ps;

  // A byte only leaves after a cycle with tx_ready high
  tx_valid_after_ready: assert property (
    @(posedge clk) disable iff (rst) tx_valid |-> $past(tx_ready)
  ) else $error("tx_valid issued after a cycle with tx_ready low");

  do_we_single_pulse: assert property (
    @(posedge clk) disable iff (rst) do_we |=> !do_we
  ) else $error("do_we held high for more than one cycle");

  // Outputs quiet while reset is applied
  quiet_in_reset: assert property (
    @(posedge clk) rst |=> (!tx_valid && !do_we)
  ) else $error("tx_valid or do_we active during reset");

endmodule

`default_nettype wire

/* tb/modbus_rtu_slave_tb.sv */
/*
 * Directed testbench for the Modbus RTU slave
 * Request driver, response collector with random back-pressure,
 * register and coil models
 */
`default_nettype none

module modbus_rtu_slave_tb import modbus_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    REG_WORDS      = 64;
  localparam word_t REG_BASE       = 16'h0100;
  localparam byte_t DEV_ADDR       = 8'h11;
  localparam int    BYTE_TIMEOUT   = 1000;
  localparam int    SILENCE_CYCLES = 300;

  logic  clk;
  logic  rst;
  byte_t rx_byte;
  logic  rx_valid;
  logic  frame_start;
  logic  frame_end;
  byte_t tx_byte;
  logic  tx_valid;
  logic  tx_ready;
  coil_t di_status;
  coil_t do_wdata;
  coil_t do_wmask;
  logic  do_we;
  logic  crc_err;

  word_t reg_model [REG_WORDS];
  coil_t coil_model;
  int    seed = 32'hdcae4dab;
  int    checks;
  int    errors;
  int    we_count;
  coil_t last_wdata;
  coil_t last_wmask;

  modbus_rtu_slave #(
    .REG_WORDS(REG_WORDS),
    .REG_BASE (REG_BASE),
    .BUF_DEPTH(256)
  ) modbus_rtu_slave_inst (.*);

  bind modbus_rtu_slave modbus_rtu_slave_checker checker_inst (
    .clk(clk), .rst(rst), .tx_valid(tx_valid), .tx_ready(tx_ready), .do_we(do_we)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Capture every digital-output write strobe
  always @(negedge clk) begin
    if (do_we) begin
      we_count++;
      last_wdata = do_wdata;
      last_wmask = do_wmask;
    end
  end

  // ====================================================================
  // Checking and reference helpers
  // ====================================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // Bitwise Modbus CRC over a whole frame
  function automatic word_t modbus_crc(input byte_t data[$]);
    word_t c;
    c = 16'hFFFF;
    foreach (data[i]) begin
      c[7:0] = c[7:0] ^ data[i];
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
      end
    end
    return c;
  endfunction

  // ====================================================================
  // Frame driver and response collector
  // ====================================================================
  task automatic send_request(input byte_t body[$], input logic corrupt);
    byte_t frame_q[$];
    crc_t  crc;
    frame_q = body;
    crc = CRC_INIT;
    foreach (body[i]) begin
      crc = crc16_step(crc, body[i]);
    end
    if (corrupt) begin
      crc = crc ^ 16'h0001;
    end
    frame_q.push_back(crc[7:0]);
    frame_q.push_back(crc[15:8]);
    foreach (frame_q[i]) begin
      @(negedge clk);
      rx_byte     = frame_q[i];
      rx_valid    = 1'b1;
      frame_start = (i == 0);
    end
    @(negedge clk);
    rx_valid    = 1'b0;
    frame_start = 1'b0;
    frame_end   = 1'b1;
    @(negedge clk);
    frame_end = 1'b0;
  endtask

  task automatic collect_response(input int count, output byte_t resp[$]);
    int idle;
    int rnd;
    resp = {};
    idle = 0;
    while (resp.size() < count && idle < BYTE_TIMEOUT) begin
      @(negedge clk);
      if (tx_valid) begin
        resp.push_back(tx_byte);
        idle = 0;
      end else begin
        idle++;
      end
      rnd = $random(seed);
      tx_ready = (rnd[1:0] != 2'b00);
    end
    checks++;
    assert (idle < BYTE_TIMEOUT) else begin
      errors++;
      $display("Timed out waiting for response byte %0d of %0d", resp.size(), count);
    end
  endtask

  task automatic expect_response(input byte_t body[$]);
    byte_t exp_q[$];
    byte_t got[$];
    word_t crc;
    exp_q = body;
    crc = modbus_crc(body);
    exp_q.push_back(crc[7:0]);
    exp_q.push_back(crc[15:8]);
    collect_response(exp_q.size(), got);
    check_value("response length", got.size(), exp_q.size());
    foreach (got[i]) begin
      check_value("tx_byte", got[i], exp_q[i]);
    end
  endtask

  // Ready held high so that any response would show up on tx_valid
  task automatic expect_silence(input int cycles);
    int seen;
    seen = 0;
    tx_ready = 1'b1;
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      if (tx_valid) begin
        seen++;
      end
    end
    checks++;
    assert (seen == 0) else begin
      errors++;
      $display("A dropped request produced %0d response bytes", seen);
    end
  endtask

  // ====================================================================
  // Request builders
  // ====================================================================
  task automatic read_holding(input word_t start, input int qty);
    byte_t req[$];
    byte_t rsp[$];
    word_t val;
    req = {DEV_ADDR, 8'h03, start[15:8], start[7:0], 8'h00, byte_t'(qty)};
    rsp = {DEV_ADDR, 8'h03, byte_t'(2 * qty)};
    for (int i = 0; i < qty; i++) begin
      val = reg_model[int'(start - REG_BASE) + i];
      rsp.push_back(val[15:8]);
      rsp.push_back(val[7:0]);
    end
    send_request(req, 1'b0);
    expect_response(rsp);
  endtask

  task automatic write_regs(input word_t start, input word_t vals[$]);
    byte_t req[$];
    byte_t rsp[$];
    req = {DEV_ADDR, 8'h10, start[15:8], start[7:0], 8'h00, byte_t'(vals.size()),
           byte_t'(2 * vals.size())};
    foreach (vals[i]) begin
      req.push_back(vals[i][15:8]);
      req.push_back(vals[i][7:0]);
      reg_model[int'(start - REG_BASE) + i] = vals[i];
    end
    rsp = req[0:5];
    send_request(req, 1'b0);
    expect_response(rsp);
  endtask

  task automatic write_coil(input word_t addr, input logic on);
    byte_t req[$];
    int    prev;
    req = {DEV_ADDR, 8'h05, addr[15:8], addr[7:0], (on ? 8'hFF : 8'h00), 8'h00};
    coil_model[addr[4:0]] = on;
    prev = we_count;
    send_request(req, 1'b0);
    expect_response(req);
    check_value("do_we pulses", we_count - prev, 1);
    check_value("do_wmask", last_wmask, 32'h1 << addr[4:0]);
    check_value("do_wdata", last_wdata, coil_model);
  endtask

  // Bits packed LSB first from the requested start
  task automatic read_bits(input byte_t fc, input word_t start, input int qty,
                           input coil_t img);
    byte_t req[$];
    byte_t rsp[$];
    byte_t b;
    int    idx;
    req = {DEV_ADDR, fc, start[15:8], start[7:0], 8'h00, byte_t'(qty)};
    rsp = {DEV_ADDR, fc, byte_t'((qty + 7) / 8)};
    for (int k = 0; k < (qty + 7) / 8; k++) begin
      b = 8'h00;
      for (int j = 0; j < 8; j++) begin
        idx = int'(start) + 8 * k + j;
        if (8 * k + j < qty && idx < 32) begin
          b[j] = img[idx[4:0]];
        end
      end
      rsp.push_back(b);
    end
    send_request(req, 1'b0);
    expect_response(rsp);
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic single_register_write();
    byte_t req[$];
    word_t addr;
    addr = REG_BASE + 16'd5;
    req = {DEV_ADDR, 8'h06, addr[15:8], addr[7:0], 8'hBE, 8'hEF};
    reg_model[5] = 16'hBEEF;
    send_request(req, 1'b0);
    expect_response(req);
    read_holding(addr, 1);
  endtask

  task automatic multiple_register_write();
    word_t vals[$];
    vals = {16'h1234, 16'h5678, 16'h9ABC, 16'hDEF0};
    write_regs(REG_BASE + 16'd8, vals);
    read_holding(REG_BASE + 16'd8, 4);
  endtask

  task automatic coil_write_and_read();
    write_coil(16'd3, 1'b1);
    write_coil(16'd10, 1'b1);
    write_coil(16'd17, 1'b1);
    write_coil(16'd10, 1'b0);
    write_coil(16'd0, 1'b1);
    read_bits(8'h01, 16'd0, 20, coil_model);
    read_bits(8'h01, 16'd2, 11, coil_model);
  endtask

  task automatic discrete_input_read();
    @(negedge clk);
    di_status = 32'hA5C3_5E71;
    read_bits(8'h02, 16'd5, 13, di_status);
    read_bits(8'h02, 16'd0, 32, di_status);
  endtask

  task automatic bad_frame_drop();
    byte_t req[$];
    word_t addr;
    addr = REG_BASE + 16'd5;
    check_value("crc_err", crc_err, 0);
    req = {DEV_ADDR, 8'h03, addr[15:8], addr[7:0], 8'h00, 8'h01};
    send_request(req, 1'b1);
    expect_silence(SILENCE_CYCLES);
    check_value("crc_err", crc_err, 1);
    // Function 04 is not supported
    req = {DEV_ADDR, 8'h04, 8'h00, 8'h00, 8'h00, 8'h01};
    send_request(req, 1'b0);
    expect_silence(SILENCE_CYCLES);
    read_holding(addr, 1);
  endtask

  task automatic backpressure_read();
    word_t vals[$];
    for (int i = 0; i < 40; i++) begin
      vals.push_back(word_t'($random(seed)));
    end
    write_regs(REG_BASE + 16'd16, vals);
    read_holding(REG_BASE + 16'd16, 40);
  endtask

  initial begin
    rst         = 1'b1;
    rx_byte     = 8'h00;
    rx_valid    = 1'b0;
    frame_start = 1'b0;
    frame_end   = 1'b0;
    tx_ready    = 1'b1;
    di_status   = '0;
    coil_model  = '0;
    checks      = 0;
    errors      = 0;
    we_count    = 0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);
    check_value("tx_valid", tx_valid, 0);
    check_value("do_wdata", do_wdata, 0);
    check_value("do_wmask", do_wmask, 0);
    single_register_write();
    multiple_register_write();
    coil_write_and_read();
    discrete_input_read();
    bad_frame_drop();
    backpressure_read();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
source/modbus_pkg.sv
source/modbus_if.sv
source/rtu_rx_frame.sv
source/holding_reg_file.sv
source/rtu_slave_exec.sv
source/rtu_tx_frame.sv
source/modbus_rtu_slave.sv
tb/modbus_rtu_slave_checker.sv
tb/modbus_rtu_slave_tb.sv

/* Makefile */
# Verilator simulation of the Modbus RTU slave

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f sim.f --top-module modbus_rtu_slave_tb -o modbus_sim
	./obj_dir/modbus_sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
